// File: tb.f
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/ctrl_exc_unit.sv
hdl/ctrl_irq_arbiter.sv
hdl/ctrl_fsm.sv
hdl/ctrl_top.sv
testbench/tb_ctrl_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_ctrl_top -o sim_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_ctrl)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: testbench/tb_ctrl_top.sv
//////////////////////////////
// directed testbench for the core controller
// inputs change on the falling edge and outputs are read 25 ns later
// decoder flags are held until the FLUSH cycle has passed
//////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module tb_ctrl_top import ctrl_pkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int SETTLE          = 25;
  // generous margin over the length of the directed tests
  localparam int WATCHDOG_CYCLES = 2000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic        instr_valid_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i;
  logic        mret_insn_i, wfi_insn_i;
  logic        instr_fetch_err_i, instr_fetch_err_plus2_i, instr_is_compressed_i;
  word_t       instr_i;
  half_t       instr_compressed_i;
  word_t       pc_id_i;
  priv_lvl_e   priv_mode_i;
  logic        csr_mstatus_tw_i, csr_mstatus_mie_i;
  logic        irq_nm_i, irq_pending_i, irq_external_i, irq_software_i;
  irq_fast_t   irq_fast_i;
  logic        stall_id_i, lsu_req_in_id_i, branch_set_i, jump_set_i;
  logic        ctrl_busy_o, instr_req_o, pc_set_o;
  pc_sel_e     pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  exc_cause_e  exc_cause_o;
  word_t       csr_mtval_o;
  logic        csr_save_if_o, csr_save_id_o, csr_save_cause_o, csr_restore_mret_o;
  logic        id_in_ready_o, instr_valid_clear_o, flush_id_o, controller_run_o;
  logic        nmi_mode_o;

  int     errors = 0;
  integer seed;

  ctrl_top u_ctrl_top (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////
  // compare helpers
  ////////////////////////////////

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // priority nmi > highest fast id > external > software > timer
  function automatic logic [5:0] expected_irq_cause(input logic nm, input irq_fast_t fast,
                                                    input logic ext, input logic sw);
    logic [5:0] cause;
    cause = 6'd39;
    if (sw) begin
      cause = 6'd35;
    end
    if (ext) begin
      cause = 6'd43;
    end
    // later (higher) lines override lower ones
    for (int i = 0; i < `CTRL_NUM_FAST_IRQ; i++) begin
      if (fast[i]) begin
        cause = 6'(48 + i);
      end
    end
    if (nm) begin
      cause = 6'd63;
    end
    return cause;
  endfunction

  ////////////////////////////////
  // stimulus helpers
  ////////////////////////////////

  // only the decoder flags drop and valid stays as it is
  task automatic clear_decode();
    illegal_insn_i          = 1'b0;
    ecall_insn_i            = 1'b0;
    ebrk_insn_i             = 1'b0;
    mret_insn_i             = 1'b0;
    wfi_insn_i              = 1'b0;
    instr_fetch_err_i       = 1'b0;
    instr_fetch_err_plus2_i = 1'b0;
    instr_is_compressed_i   = 1'b0;
    branch_set_i            = 1'b0;
    jump_set_i              = 1'b0;
  endtask

  task automatic drive_irq_lines(input logic nm, input irq_fast_t fast, input logic ext,
                                 input logic sw);
    irq_nm_i       = nm;
    irq_fast_i     = fast;
    irq_external_i = ext;
    irq_software_i = sw;
    irq_pending_i  = (|fast) | ext | sw;
  endtask

  // request cycle in DECODE followed by the FLUSH cycle
  task automatic flush_exception(input logic [5:0] cause, input word_t mtval);
    #(SETTLE);
    compare_bit("id_in_ready_o", id_in_ready_o, 1'b0);
    compare_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b0);
    compare_bit("pc_set_o in DECODE", pc_set_o, 1'b0);
    compare_bit("flush_id_o in DECODE", flush_id_o, 1'b0);
    @(negedge clk_i);
    #(SETTLE);
    compare_bit("flush_id_o", flush_id_o, 1'b1);
    compare_bit("instr_valid_clear_o in FLUSH", instr_valid_clear_o, 1'b1);
    compare_bit("pc_set_o", pc_set_o, 1'b1);
    compare_word("pc_mux_o", word_t'(pc_mux_o), word_t'(PC_EXC));
    compare_word("exc_pc_mux_o", word_t'(exc_pc_mux_o), word_t'(EXC_PC_EXC));
    compare_bit("csr_save_id_o", csr_save_id_o, 1'b1);
    compare_bit("csr_save_cause_o", csr_save_cause_o, 1'b1);
    compare_word("exc_cause_o", word_t'(exc_cause_o), word_t'(cause));
    compare_word("csr_mtval_o", csr_mtval_o, mtval);
    @(negedge clk_i);
    clear_decode();
  endtask

  // DECODE with fetch halted followed by IRQ_TAKEN
  task automatic irq_entry(input logic [5:0] cause);
    #(SETTLE);
    compare_bit("id_in_ready_o", id_in_ready_o, 1'b0);
    @(negedge clk_i);
    #(SETTLE);
    compare_bit("pc_set_o", pc_set_o, 1'b1);
    compare_word("pc_mux_o", word_t'(pc_mux_o), word_t'(PC_EXC));
    compare_word("exc_pc_mux_o", word_t'(exc_pc_mux_o), word_t'(EXC_PC_IRQ));
    compare_bit("csr_save_if_o", csr_save_if_o, 1'b1);
    compare_bit("csr_save_cause_o", csr_save_cause_o, 1'b1);
    compare_word("exc_cause_o", word_t'(exc_cause_o), word_t'(cause));
    @(negedge clk_i);
    drive_irq_lines(1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic irq_ignored(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      #(SETTLE);
      compare_bit("csr_save_if_o while masked", csr_save_if_o, 1'b0);
      compare_bit("pc_set_o while masked", pc_set_o, 1'b0);
      @(negedge clk_i);
    end
  endtask

  task automatic wait_for_run(input string where);
    int waited;
    waited = 0;
    #(SETTLE);
    while (!controller_run_o && waited < 8) begin
      @(negedge clk_i);
      #(SETTLE);
      waited++;
    end
    if (!controller_run_o) begin
      $display("controller_run_o never rose %s", where);
      errors++;
    end
    @(negedge clk_i);
  endtask

  ////////////////////////////////
  // directed tests
  ////////////////////////////////

  task automatic boot_sequence();
    #(SETTLE);
    compare_bit("ctrl_busy_o in RESET", ctrl_busy_o, 1'b0);
    compare_bit("instr_req_o in RESET", instr_req_o, 1'b0);
    compare_bit("pc_set_o in RESET", pc_set_o, 1'b1);
    compare_word("pc_mux_o in RESET", word_t'(pc_mux_o), word_t'(PC_BOOT));
    @(negedge clk_i);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    // BOOT_SET
    #(SETTLE);
    compare_bit("pc_set_o in BOOT_SET", pc_set_o, 1'b1);
    compare_word("pc_mux_o in BOOT_SET", word_t'(pc_mux_o), word_t'(PC_BOOT));
    compare_bit("instr_req_o in BOOT_SET", instr_req_o, 1'b1);
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    wait_for_run("after boot");
  endtask

  task automatic sync_exceptions();
    instr_i        = word_t'($random(seed));
    illegal_insn_i = 1'b1;
    flush_exception(6'd2, instr_i);
    // compressed form gives the zero-extended half as mtval
    instr_compressed_i    = half_t'($random(seed));
    instr_is_compressed_i = 1'b1;
    illegal_insn_i        = 1'b1;
    flush_exception(6'd2, word_t'(instr_compressed_i));
    // fetch error outranks illegal with the fault in the upper half
    pc_id_i                 = word_t'($random(seed));
    illegal_insn_i          = 1'b1;
    instr_fetch_err_i       = 1'b1;
    instr_fetch_err_plus2_i = 1'b1;
    flush_exception(6'd1, pc_id_i + 32'd2);
    ecall_insn_i = 1'b1;
    flush_exception(6'd11, '0);
    priv_mode_i  = PRIV_LVL_U;
    ecall_insn_i = 1'b1;
    flush_exception(6'd8, '0);
    // MRET only legal in M-mode
    instr_i     = word_t'($random(seed));
    mret_insn_i = 1'b1;
    flush_exception(6'd2, instr_i);
    priv_mode_i = PRIV_LVL_M;
  endtask

  task automatic branch_redirect();
    branch_set_i = 1'b1;
    #(SETTLE);
    compare_bit("pc_set_o on branch", pc_set_o, 1'b1);
    compare_word("pc_mux_o on branch", word_t'(pc_mux_o), word_t'(PC_JUMP));
    @(negedge clk_i);
    branch_set_i = 1'b0;
    jump_set_i   = 1'b1;
    #(SETTLE);
    compare_bit("pc_set_o on jump", pc_set_o, 1'b1);
    compare_word("pc_mux_o on jump", word_t'(pc_mux_o), word_t'(PC_JUMP));
    @(negedge clk_i);
    jump_set_i = 1'b0;
    // fetch error blocks the redirect and goes to FLUSH
    pc_id_i           = word_t'($random(seed));
    branch_set_i      = 1'b1;
    instr_fetch_err_i = 1'b1;
    flush_exception(6'd1, pc_id_i);
  endtask

  task automatic interrupt_priority();
    drive_irq_lines(1'b0, 15'h0208, 1'b0, 1'b0);
    irq_entry(expected_irq_cause(irq_nm_i, irq_fast_i, irq_external_i, irq_software_i));
    drive_irq_lines(1'b0, '0, 1'b1, 1'b1);
    irq_entry(expected_irq_cause(irq_nm_i, irq_fast_i, irq_external_i, irq_software_i));
    csr_mstatus_mie_i = 1'b0;
    drive_irq_lines(1'b0, '0, 1'b1, 1'b0);
    irq_ignored(4);
    drive_irq_lines(1'b0, '0, 1'b0, 1'b0);
    csr_mstatus_mie_i = 1'b1;
    drive_irq_lines(1'b1, '0, 1'b0, 1'b0);
    irq_entry(expected_irq_cause(irq_nm_i, irq_fast_i, irq_external_i, irq_software_i));
    #(SETTLE);
    compare_bit("nmi_mode_o after NMI", nmi_mode_o, 1'b1);
    @(negedge clk_i);
    // nothing nests inside the NMI handler
    drive_irq_lines(1'b1, 15'h0001, 1'b1, 1'b0);
    irq_ignored(3);
    drive_irq_lines(1'b0, '0, 1'b0, 1'b0);
    mret_insn_i = 1'b1;
    #(SETTLE);
    compare_bit("id_in_ready_o on MRET", id_in_ready_o, 1'b0);
    @(negedge clk_i);
    #(SETTLE);
    compare_bit("pc_set_o on MRET", pc_set_o, 1'b1);
    compare_word("pc_mux_o on MRET", word_t'(pc_mux_o), word_t'(PC_ERET));
    compare_bit("csr_restore_mret_o", csr_restore_mret_o, 1'b1);
    compare_bit("csr_save_id_o on MRET", csr_save_id_o, 1'b0);
    @(negedge clk_i);
    clear_decode();
    #(SETTLE);
    compare_bit("nmi_mode_o after MRET", nmi_mode_o, 1'b0);
    @(negedge clk_i);
  endtask

  task automatic wfi_sleep();
    int waited;
    waited     = 0;
    wfi_insn_i = 1'b1;
    #(SETTLE);
    while ((ctrl_busy_o || instr_req_o) && waited < 3) begin
      @(negedge clk_i);
      #(SETTLE);
      waited++;
    end
    if (ctrl_busy_o || instr_req_o) begin
      $display("core still busy or fetching three cycles after WFI");
      errors++;
    end
    @(negedge clk_i);
    clear_decode();
    instr_valid_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      #(SETTLE);
      compare_bit("ctrl_busy_o asleep", ctrl_busy_o, 1'b0);
      compare_bit("instr_req_o asleep", instr_req_o, 1'b0);
      compare_bit("flush_id_o asleep", flush_id_o, 1'b1);
      @(negedge clk_i);
    end
    // wake without taking the interrupt
    csr_mstatus_mie_i = 1'b0;
    irq_pending_i     = 1'b1;
    #(SETTLE);
    compare_bit("ctrl_busy_o on wake", ctrl_busy_o, 1'b1);
    @(negedge clk_i);
    irq_pending_i     = 1'b0;
    csr_mstatus_mie_i = 1'b1;
    instr_valid_i     = 1'b1;
    wait_for_run("after wake-up");
    // TW traps WFI outside M-mode
    priv_mode_i      = PRIV_LVL_U;
    csr_mstatus_tw_i = 1'b1;
    instr_i          = word_t'($random(seed));
    wfi_insn_i       = 1'b1;
    flush_exception(6'd2, instr_i);
    priv_mode_i      = PRIV_LVL_M;
    csr_mstatus_tw_i = 1'b0;
  endtask

  task automatic stall_hold();
    stall_id_i = 1'b1;
    #(SETTLE);
    compare_bit("id_in_ready_o stalled", id_in_ready_o, 1'b0);
    compare_bit("instr_valid_clear_o stalled", instr_valid_clear_o, 1'b0);
    @(negedge clk_i);
    drive_irq_lines(1'b0, '0, 1'b1, 1'b0);
    for (int i = 0; i < 3; i++) begin
      #(SETTLE);
      compare_bit("id_in_ready_o stalled", id_in_ready_o, 1'b0);
      compare_bit("instr_valid_clear_o stalled", instr_valid_clear_o, 1'b0);
      compare_bit("csr_save_if_o stalled", csr_save_if_o, 1'b0);
      compare_bit("pc_set_o stalled", pc_set_o, 1'b0);
      @(negedge clk_i);
    end
    stall_id_i = 1'b0;
    irq_entry(expected_irq_cause(irq_nm_i, irq_fast_i, irq_external_i, irq_software_i));
  endtask

  initial begin
    seed              = 88;
    rst_ni            = 1'b0;
    fetch_enable_i    = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    instr_compressed_i = '0;
    pc_id_i           = '0;
    priv_mode_i       = PRIV_LVL_M;
    csr_mstatus_tw_i  = 1'b0;
    csr_mstatus_mie_i = 1'b1;
    stall_id_i        = 1'b0;
    lsu_req_in_id_i   = 1'b0;
    clear_decode();
    drive_irq_lines(1'b0, '0, 1'b0, 1'b0);
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    boot_sequence();
    sync_exceptions();
    branch_redirect();
    interrupt_priority();
    wfi_sleep();
    stall_hold();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: hdl/ctrl_top.sv
//////////////////////////////
// core controller top, exception unit + irq arbiter + FSM
//////////////////////////////

`timescale 1ns/1ps

module ctrl_top import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  // decoder and IF/ID register
  input  logic        instr_valid_i,
  input  logic        illegal_insn_i,
  input  logic        ecall_insn_i,
  input  logic        ebrk_insn_i,
  input  logic        mret_insn_i,
  input  logic        wfi_insn_i,
  input  logic        instr_fetch_err_i,
  input  logic        instr_fetch_err_plus2_i,
  input  logic        instr_is_compressed_i,
  input  word_t       instr_i,
  input  half_t       instr_compressed_i,
  input  word_t       pc_id_i,
  // CSR state
  input  priv_lvl_e   priv_mode_i,
  input  logic        csr_mstatus_tw_i,
  input  logic        csr_mstatus_mie_i,
  // interrupts
  input  logic        irq_nm_i,
  input  logic        irq_pending_i,
  input  irq_fast_t   irq_fast_i,
  input  logic        irq_external_i,
  input  logic        irq_software_i,
  // ID/EX status
  input  logic        stall_id_i,
  input  logic        lsu_req_in_id_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  output logic        ctrl_busy_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output exc_cause_e  exc_cause_o,
  output word_t       csr_mtval_o,
  output logic        csr_save_if_o,
  output logic        csr_save_id_o,
  output logic        csr_save_cause_o,
  output logic        csr_restore_mret_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,
  output logic        controller_run_o,
  output logic        nmi_mode_o
);

  logic       in_flush, special_req, fetch_err_branch, exc_req, mret, wfi;
  logic       handle_irq, irq_is_nmi;
  exc_cause_e exc_cause, irq_cause;
  word_t      mtval;

  ctrl_exc_unit u_exc_unit (
    .clk_i, .rst_ni, .instr_valid_i, .illegal_insn_i, .ecall_insn_i, .ebrk_insn_i,
    .mret_insn_i, .wfi_insn_i, .instr_fetch_err_i, .instr_fetch_err_plus2_i,
    .instr_is_compressed_i, .instr_i, .instr_compressed_i, .pc_id_i, .priv_mode_i,
    .csr_mstatus_tw_i,
    .in_flush_i         (in_flush),
    .special_req_o      (special_req),
    .fetch_err_branch_o (fetch_err_branch),
    .exc_req_o          (exc_req),
    .mret_o             (mret),
    .wfi_o              (wfi),
    .exc_cause_o        (exc_cause),
    .mtval_o            (mtval)
  );

  ctrl_irq_arbiter u_irq_arbiter (
    .irq_nm_i, .irq_pending_i, .csr_mstatus_mie_i, .irq_fast_i, .irq_external_i,
    .irq_software_i,
    .nmi_mode_i   (nmi_mode_o),
    .handle_irq_o (handle_irq),
    .irq_cause_o  (irq_cause),
    .irq_is_nmi_o (irq_is_nmi)
  );

  ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .fetch_enable_i, .instr_valid_i, .stall_id_i, .lsu_req_in_id_i,
    .branch_set_i, .jump_set_i, .irq_nm_i, .irq_pending_i,
    .special_req_i      (special_req),
    .fetch_err_branch_i (fetch_err_branch),
    .exc_req_i          (exc_req),
    .mret_i             (mret),
    .wfi_i              (wfi),
    .handle_irq_i       (handle_irq),
    .irq_is_nmi_i       (irq_is_nmi),
    .exc_cause_i        (exc_cause),
    .irq_cause_i        (irq_cause),
    .mtval_i            (mtval),
    .ctrl_busy_o, .instr_req_o, .pc_set_o, .pc_mux_o, .exc_pc_mux_o, .exc_cause_o,
    .csr_mtval_o, .csr_save_if_o, .csr_save_id_o, .csr_save_cause_o, .csr_restore_mret_o,
    .id_in_ready_o, .instr_valid_clear_o, .flush_id_o, .controller_run_o, .nmi_mode_o,
    .in_flush_o         (in_flush)
  );

endmodule

// File: hdl/ctrl_fsm.sv
//////////////////////////////
// controller FSM with one FLUSH cycle per special request
// no writeback stage and no debug mode
// pc_mux_o is only meaningful while pc_set_o is high
//////////////////////////////

`timescale 1ns/1ps

module ctrl_fsm import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  logic        stall_id_i,
  input  logic        lsu_req_in_id_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        irq_nm_i,
  input  logic        irq_pending_i,
  input  logic        special_req_i,
  input  logic        fetch_err_branch_i,
  input  logic        exc_req_i,
  input  logic        mret_i,
  input  logic        wfi_i,
  input  logic        handle_irq_i,
  input  logic        irq_is_nmi_i,
  input  exc_cause_e  exc_cause_i,
  input  exc_cause_e  irq_cause_i,
  input  word_t       mtval_i,
  output logic        ctrl_busy_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output exc_cause_e  exc_cause_o,
  output word_t       csr_mtval_o,
  output logic        csr_save_if_o,
  output logic        csr_save_id_o,
  output logic        csr_save_cause_o,
  output logic        csr_restore_mret_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,
  output logic        controller_run_o,
  output logic        nmi_mode_o,
  output logic        in_flush_o
);

  ctrl_fsm_e state_q, state_d;
  logic      nmi_mode_q, nmi_mode_d;
  logic      halt_if, retain_id, flush_id;

  always_comb begin
    state_d            = state_q;
    nmi_mode_d         = nmi_mode_q;
    ctrl_busy_o        = 1'b1;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = irq_cause_i;
    csr_mtval_o        = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    controller_run_o   = 1'b0;
    halt_if            = 1'b0;
    retain_id          = 1'b0;
    flush_id           = 1'b0;

    unique case (state_q)
      RESET: begin
        // boot PC already on the mux while waiting for enable
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // any pending source wakes even with MIE clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        // ID is ready here whenever it is not stalled
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      DECODE: begin
        // run mode while a valid instr sits in ID
        controller_run_o = instr_valid_i;
        pc_mux_o         = PC_JUMP;
        if (special_req_i) begin
          // keep the instr in ID for FLUSH to inspect
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if ((branch_set_i || jump_set_i) && !fetch_err_branch_i) begin
          pc_set_o = 1'b1;
        end
        // interrupt waits for the current instr to finish
        if (handle_irq_i && (stall_id_i || lsu_req_in_id_i)) begin
          halt_if = 1'b1;
        end
        if (handle_irq_i && !stall_id_i && !lsu_req_in_id_i && !special_req_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          if (irq_is_nmi_i) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc_req_i) begin
          // epc is the PC of the instr in ID
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = exc_cause_i;
          csr_mtval_o      = mtval_i;
        end else if (mret_i) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          // leaving the NMI handler
          nmi_mode_d         = 1'b0;
        end else if (wfi_i) begin
          state_d = WAIT_SLEEP;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////
  // IF/ID stall control
  ////////////////////////////////

  assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
  // retain keeps valid set unless a flush kills it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;
  assign nmi_mode_o          = nmi_mode_q;
  assign in_flush_o          = (state_q == FLUSH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

// File: hdl/ctrl_irq_arbiter.sv
//////////////////////////////
// interrupt take decision and cause encode
// timer is the fallback cause, no timer line needed
//////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_irq_arbiter import ctrl_pkg::*; (
  input  logic       irq_nm_i,
  input  logic       irq_pending_i,
  input  logic       csr_mstatus_mie_i,
  input  irq_fast_t  irq_fast_i,
  input  logic       irq_external_i,
  input  logic       irq_software_i,
  input  logic       nmi_mode_i,
  output logic       handle_irq_o,
  output exc_cause_e irq_cause_o,
  output logic       irq_is_nmi_o
);

  fast_id_t mfip_id;

  // no nesting while an NMI handler runs
  assign handle_irq_o = ~nmi_mode_i & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));
  assign irq_is_nmi_o = irq_nm_i & ~nmi_mode_i;

  // ascending scan so the highest set line wins
  always_comb begin
    mfip_id = '0;
    for (int i = 0; i < `CTRL_NUM_FAST_IRQ; i++) begin
      if (irq_fast_i[i]) begin
        mfip_id = fast_id_t'(i);
      end
    end
  end

  // nmi > fast > external > software > timer
  always_comb begin
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (irq_fast_i != '0) begin
      // top two bits give the irq flag and the +16 offset
      irq_cause_o = exc_cause_e'({2'b11, mfip_id});
    end else if (irq_external_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_software_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

endmodule

// File: hdl/ctrl_exc_unit.sv
//////////////////////////////
// synchronous exception detect and prioritisation
// cause and mtval only hold meaning in FLUSH with exc_req_o set
//////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_exc_unit import ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       instr_valid_i,
  input  logic       illegal_insn_i,
  input  logic       ecall_insn_i,
  input  logic       ebrk_insn_i,
  input  logic       mret_insn_i,
  input  logic       wfi_insn_i,
  input  logic       instr_fetch_err_i,
  input  logic       instr_fetch_err_plus2_i,
  input  logic       instr_is_compressed_i,
  input  word_t      instr_i,
  input  half_t      instr_compressed_i,
  input  word_t      pc_id_i,
  input  priv_lvl_e  priv_mode_i,
  input  logic       csr_mstatus_tw_i,
  input  logic       in_flush_i,
  output logic       special_req_o,
  output logic       fetch_err_branch_o,
  output logic       exc_req_o,
  output logic       mret_o,
  output logic       wfi_o,
  output exc_cause_e exc_cause_o,
  output word_t      mtval_o
);

  logic ecall, ebrk, fetch_err, illegal_umode;
  logic illegal_insn_d, illegal_insn_q;
  logic exc_req_d, exc_req_q;

  // decoder flags carry no valid of their own
  assign ecall     = ecall_insn_i & instr_valid_i;
  assign ebrk      = ebrk_insn_i & instr_valid_i;
  assign mret_o    = mret_insn_i & instr_valid_i;
  assign wfi_o     = wfi_insn_i & instr_valid_i;
  assign fetch_err = instr_fetch_err_i & instr_valid_i;

  // MRET always M-mode only, WFI only when TW traps it
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) & (mret_o | (csr_mstatus_tw_i & wfi_o));

  // dropped in FLUSH so a handled request does not repeat
  assign illegal_insn_d = ((illegal_insn_i & instr_valid_i) | illegal_umode) & ~in_flush_i;
  assign exc_req_d      = (ecall | ebrk | illegal_insn_d | fetch_err) & ~in_flush_i;

  assign special_req_o      = mret_o | wfi_o | exc_req_d;
  // only reason a branch may not redirect
  assign fetch_err_branch_o = fetch_err & ~in_flush_i;
  assign exc_req_o          = exc_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_req_q      <= 1'b0;
      illegal_insn_q <= 1'b0;
    end else begin
      exc_req_q      <= exc_req_d;
      illegal_insn_q <= illegal_insn_d;
    end
  end

  // fetch error > illegal > ecall > ebreak
  always_comb begin
    exc_cause_o = EXC_CAUSE_BREAKPOINT;
    mtval_o     = '0;
    if (fetch_err) begin
      exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // fault may sit in the upper half of a straddling instr
      mtval_o     = instr_fetch_err_plus2_i ? (pc_id_i + word_t'(2)) : pc_id_i;
    end else if (illegal_insn_q) begin
      exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
      mtval_o     = instr_is_compressed_i ?
                    {{(`CTRL_XLEN-`CTRL_HALF){1'b0}}, instr_compressed_i} : instr_i;
    end else if (ecall) begin
      exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end
  end

endmodule

// File: hdl/ctrl_pkg.sv
//////////////////////////////
// controller types, widths taken from the defs header
// cause codes follow the RISC-V privileged spec
//////////////////////////////

`include "ctrl_defs.svh"

package ctrl_pkg;

  typedef logic [`CTRL_XLEN-1:0]         word_t;
  typedef logic [`CTRL_HALF-1:0]         half_t;
  typedef logic [`CTRL_NUM_FAST_IRQ-1:0] irq_fast_t;
  typedef logic [`CTRL_FAST_ID_W-1:0]    fast_id_t;

  // fetch address source
  typedef enum logic [1:0] {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET} pc_sel_e;

  // handler address source
  typedef enum logic {EXC_PC_IRQ, EXC_PC_EXC} exc_pc_sel_e;

  // fast interrupt n maps to 48 + n
  typedef enum logic [`CTRL_CAUSE_W-1:0] {
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_ECALL_UMODE        = 6'd8,
    EXC_CAUSE_ECALL_MMODE        = 6'd11,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'd35,
    EXC_CAUSE_IRQ_TIMER_M        = 6'd39,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'd43,
    EXC_CAUSE_IRQ_FAST_0         = 6'd48,
    EXC_CAUSE_IRQ_NM             = 6'd63
  } exc_cause_e;

  typedef enum logic [1:0] {PRIV_LVL_U = 2'b00, PRIV_LVL_M = 2'b11} priv_lvl_e;

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

endpackage

// File: hdl/ctrl_defs.svh
//////////////////////////////
// width macros for the core controller
// fast IRQ count must fit in CTRL_FAST_ID_W bits
// cause width holds the interrupt flag in its top bit
//////////////////////////////

`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// data word, PC and mtval width
`define CTRL_XLEN 32

// compressed instruction width
`define CTRL_HALF 16

// fast interrupt lines and their index width
`define CTRL_NUM_FAST_IRQ 15
`define CTRL_FAST_ID_W 4

// mcause code width, bit 5 marks an interrupt
`define CTRL_CAUSE_W 6

`endif
